/* include/decode_params.svh */
// shared sizes for the offset decoder and these values are fixed by the byte layout of the selector
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// bytes in one instruction window
// byte 1 is the most significant byte
`define WINDOW_BYTES 16

// width of the extracted offset in bits
// wide enough for a ptr16:32 far pointer
`define OFFSET_WIDTH 48

// prefixes allowed ahead of the opcode
// one more prefix than this marks the window illegal
`define MAX_PREFIXES 3

`endif

/* hdl/decode_pkg.sv */
// types shared by every stage of the offset decoder and the field widths follow decode_params.svh
`include "decode_params.svh"

package decode_pkg;

    // width of the field that follows the opcode
    // size48 is only used by the far pointer forms
    typedef enum logic [1:0] {
        size8  = 2'd0,
        size16 = 2'd1,
        size32 = 2'd2,
        size48 = 2'd3
    } offset_size_e;

    // controls produced by the length decoder
    typedef struct packed {
        // start byte code as the selector expects it
        logic [2:0]   off_sel;
        offset_size_e offset_size;
        // ptr16:16 form, selector moves up to offset[47:32]
        logic         ovr;
        logic [3:0]   instr_length;
        logic         illegal;
    } decode_ctrl_t;

    // what leaves the pipeline
    typedef struct packed {
        logic [`OFFSET_WIDTH-1:0] offset;
        logic [3:0]               instr_length;
        logic                     illegal;
    } decode_result_t;

    // first pipeline stage carries the raw window along with its controls
    typedef struct packed {
        logic [`WINDOW_BYTES*8-1:0] window;
        decode_ctrl_t               ctrl;
    } stage1_t;

endpackage

/* hdl/instr_length_decoder.sv */
// decodes only the branch and far-transfer subset and any other opcode or a fourth prefix is flagged illegal
`timescale 1ns/1ps
`include "decode_params.svh"

module instr_length_decoder
    import decode_pkg::*;
(
    input  logic [`WINDOW_BYTES*8-1:0] window,
    output decode_ctrl_t               ctrl
);

    // window split into bytes, byte 1 first
    logic [7:0] win_byte [1:`WINDOW_BYTES];

    logic [1:0]   prefix_cnt;
    logic         too_many;
    logic         override;
    logic         scanning;
    logic [7:0]   op0;
    logic [7:0]   op1;
    logic         two_byte;
    logic         known;
    logic         far_ptr;
    offset_size_e size;
    logic [2:0]   field_start;
    logic [2:0]   off_code;
    logic [3:0]   field_bytes;
    logic         illegal;

    // operand-size override and the two ignored segment prefixes
    function automatic logic is_prefix(input logic [7:0] b);
        return (b == 8'h66) || (b == 8'h2e) || (b == 8'h3e);
    endfunction

    always_comb begin
        for (int i = 1; i <= `WINDOW_BYTES; i++) begin
            win_byte[i] = window[8*(`WINDOW_BYTES-i) +: 8];
        end
    end

    // count leading prefixes
    // one byte past the limit is looked at so a fourth prefix can be caught
    always_comb begin
        prefix_cnt = 2'd0;
        too_many   = 1'b0;
        override   = 1'b0;
        scanning   = 1'b1;
        for (int i = 1; i <= `MAX_PREFIXES + 1; i++) begin
            if (scanning && is_prefix(win_byte[i])) begin
                if (i > `MAX_PREFIXES) begin
                    too_many = 1'b1;
                end else begin
                    prefix_cnt = prefix_cnt + 2'd1;
                    if (win_byte[i] == 8'h66) begin
                        override = 1'b1;
                    end
                end
            end else begin
                scanning = 1'b0;
            end
        end
    end

    // opcode sits right after the prefixes, second byte only matters for 0F
    assign op0 = win_byte[prefix_cnt + 1];
    assign op1 = win_byte[prefix_cnt + 2];

    // opcode classification
    always_comb begin
        two_byte = 1'b0;
        known    = 1'b1;
        far_ptr  = 1'b0;
        size     = size8;
        if (op0 == 8'h0f) begin
            two_byte = 1'b1;
            // jcc rel32 family
            if (op1[7:4] == 4'h8) begin
                size = override ? size16 : size32;
            end else begin
                known = 1'b0;
            end
        end else if ((op0 == 8'heb) || (op0[7:4] == 4'h7)) begin
            // short jmp and short jcc
            size = size8;
        end else if ((op0 == 8'he8) || (op0 == 8'he9)) begin
            size = override ? size16 : size32;
        end else if (op0 == 8'hc2) begin
            // ret imm16 ignores the override
            size = size16;
        end else if ((op0 == 8'hea) || (op0 == 8'h9a)) begin
            far_ptr = 1'b1;
            size    = override ? size32 : size48;
        end else begin
            known = 1'b0;
        end
    end

    // first field byte, 2 to 6
    assign field_start = {1'b0, prefix_cnt} + (two_byte ? 3'd2 : 3'd1) + 3'd1;

    // selector start code
    always_comb begin
        case (field_start)
            3'd2:    off_code = 3'd5;
            3'd3:    off_code = 3'd6;
            3'd4:    off_code = 3'd7;
            3'd5:    off_code = 3'd4;
            default: off_code = 3'd0;
        endcase
    end

    always_comb begin
        case (size)
            size8:   field_bytes = 4'd1;
            size16:  field_bytes = 4'd2;
            size32:  field_bytes = 4'd4;
            default: field_bytes = 4'd6;
        endcase
    end

    assign illegal = too_many || !known;

    // illegal windows get size8 and zero length
    always_comb begin
        ctrl.off_sel      = illegal ? 3'd0 : off_code;
        ctrl.offset_size  = illegal ? size8 : size;
        ctrl.ovr          = !illegal && far_ptr && override;
        ctrl.instr_length = illegal ? 4'd0 : {1'b0, field_start} - 4'd1 + field_bytes;
        ctrl.illegal      = illegal;
    end

endmodule

/* hdl/offset_selector.sv */
// field bytes must start between window bytes 2 and 6 and off_sel uses the start code of the length decoder
`timescale 1ns/1ps
`include "decode_params.svh"

module offset_selector
    import decode_pkg::*;
(
    input  logic [`WINDOW_BYTES*8-1:0] window,
    input  logic [2:0]                 off_sel,
    input  offset_size_e               offset_size,
    input  logic                       ovr,
    output logic [`OFFSET_WIDTH-1:0]   offset
);

    // only bytes 2 through 11 can hold a field byte
    logic [7:0] win_byte [2:11];
    // first level picks among starts 2 to 5
    logic [7:0] lvl1 [0:5];
    // second level adds start 6
    logic [7:0] field [0:5];
    logic       keep_byte1;
    logic       wide;
    logic       full;

    always_comb begin
        for (int k = 2; k <= 11; k++) begin
            win_byte[k] = window[8*(`WINDOW_BYTES-k) +: 8];
        end
    end

    // two mux levels per field byte
    always_comb begin
        for (int k = 0; k < 6; k++) begin
            case (off_sel[1:0])
                2'd0: lvl1[k] = win_byte[5+k];
                2'd1: lvl1[k] = win_byte[2+k];
                2'd2: lvl1[k] = win_byte[3+k];
                default: lvl1[k] = win_byte[4+k];
            endcase
            // codes 0 to 3 all mean start byte 6
            field[k] = off_sel[2] ? lvl1[k] : win_byte[6+k];
        end
    end

    // size decode
    assign keep_byte1 = (offset_size != size8);
    assign wide       = offset_size[1];
    assign full       = (offset_size == size48);

    always_comb begin
        // low byte is always passed
        offset[7:0]  = field[0];
        offset[15:8] = keep_byte1 ? field[1] : 8'h00;
        // upper half of a 32-bit field, blanked when the selector goes up
        offset[31:16] = (wide && !ovr) ? {field[3], field[2]} : 16'h0000;
        // segment selector of a far pointer
        case ({ovr, full})
            2'b01:   offset[47:32] = {field[5], field[4]};
            2'b10:   offset[47:32] = {field[3], field[2]};
            2'b11:   offset[47:32] = {field[5], field[4]};
            default: offset[47:32] = 16'h0000;
        endcase
    end

endmodule

/* hdl/stage_register.sv */
// one pipeline stage with no stall input and a new load always overwrites the held payload
`timescale 1ns/1ps

module stage_register #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     load,
    input  payload_t din,
    output logic     valid,
    output payload_t dout
);

    // valid tracks load one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= load;
        end
    end

    // payload only moves on load
    // contents are don't care while valid is low
    always_ff @(posedge clk) begin
        if (load) begin
            dout <= din;
        end
    end

endmodule

/* hdl/offset_decode_top.sv */
// two-cycle pipeline with no back-pressure and out_valid follows in_valid exactly two edges later
`timescale 1ns/1ps
`include "decode_params.svh"

module offset_decode_top
    import decode_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  logic [`WINDOW_BYTES*8-1:0] in_window,
    output logic                       out_valid,
    output decode_result_t             out_result
);

    decode_ctrl_t             dec_ctrl;
    stage1_t                  stage1_din;
    stage1_t                  stage1_q;
    logic                     stage1_valid;
    logic [`OFFSET_WIDTH-1:0] sel_offset;
    decode_result_t           result_d;

    // prefix and opcode decode straight off the input window
    instr_length_decoder u_decoder (
        .window (in_window),
        .ctrl   (dec_ctrl)
    );

    assign stage1_din = '{window: in_window, ctrl: dec_ctrl};

    stage_register #(
        .payload_t (stage1_t)
    ) u_stage1 (
        .clk   (clk),
        .reset (reset),
        .load  (in_valid),
        .din   (stage1_din),
        .valid (stage1_valid),
        .dout  (stage1_q)
    );

    // byte steering in the second cycle
    offset_selector u_selector (
        .window      (stage1_q.window),
        .off_sel     (stage1_q.ctrl.off_sel),
        .offset_size (stage1_q.ctrl.offset_size),
        .ovr         (stage1_q.ctrl.ovr),
        .offset      (sel_offset)
    );

    // illegal windows leave with a zero offset
    assign result_d = '{
        offset:       stage1_q.ctrl.illegal ? {`OFFSET_WIDTH{1'b0}} : sel_offset,
        instr_length: stage1_q.ctrl.instr_length,
        illegal:      stage1_q.ctrl.illegal
    };

    stage_register #(
        .payload_t (decode_result_t)
    ) u_stage2 (
        .clk   (clk),
        .reset (reset),
        .load  (stage1_valid),
        .din   (result_d),
        .valid (out_valid),
        .dout  (out_result)
    );

endmodule

/* test/offset_decode_tb.sv */
// expected results come from decode_ref in this file and each result must appear exactly two edges after its input
`timescale 1ns/1ps
`include "decode_params.svh"

module offset_decode_tb
    import decode_pkg::*;
;

    logic                       clk;
    logic                       reset;
    logic                       in_valid;
    logic [`WINDOW_BYTES*8-1:0] in_window;
    logic                       out_valid;
    decode_result_t             out_result;

    integer         seed = 32'hee1f_163f;
    int             cyc = 0;
    int             mismatch_count = 0;
    int             protocol_count = 0;
    // expected results and the edge at which each must be visible
    decode_result_t exp_q [$];
    int             due_q [$];

    offset_decode_top offset_decode_top_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_window  (in_window),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // expected decode of one window, byte 1 is the top byte
    function automatic decode_result_t decode_ref(input logic [`WINDOW_BYTES*8-1:0] w);
        decode_result_t r;
        logic [7:0]     b [1:`WINDOW_BYTES];
        logic [7:0]     op;
        int             p;
        int             s;
        int             nbytes;
        bit             has66;
        bit             two;
        bit             far;
        bit             legal;
        offset_size_e   sz;
        for (int i = 1; i <= `WINDOW_BYTES; i++) begin
            b[i] = w[8*(`WINDOW_BYTES-i) +: 8];
        end
        r = '0;
        p = 0;
        has66 = 1'b0;
        // a fourth prefix is counted so it can be rejected
        while (p <= `MAX_PREFIXES && (b[p+1] == 8'h66 || b[p+1] == 8'h2e || b[p+1] == 8'h3e)) begin
            if (b[p+1] == 8'h66) begin
                has66 = 1'b1;
            end
            p++;
        end
        if (p > `MAX_PREFIXES) begin
            r.illegal = 1'b1;
            return r;
        end
        op = b[p+1];
        two = (op == 8'h0f);
        far = 1'b0;
        legal = 1'b1;
        sz = size8;
        if (two) begin
            if (b[p+2][7:4] == 4'h8) begin
                sz = has66 ? size16 : size32;
            end else begin
                legal = 1'b0;
            end
        end else if (op == 8'heb || op[7:4] == 4'h7) begin
            sz = size8;
        end else if (op == 8'he8 || op == 8'he9) begin
            sz = has66 ? size16 : size32;
        end else if (op == 8'hc2) begin
            sz = size16;
        end else if (op == 8'hea || op == 8'h9a) begin
            far = 1'b1;
            sz = has66 ? size32 : size48;
        end else begin
            legal = 1'b0;
        end
        if (!legal) begin
            r.illegal = 1'b1;
            return r;
        end
        s = p + (two ? 2 : 1) + 1;
        case (sz)
            size8:   nbytes = 1;
            size16:  nbytes = 2;
            size32:  nbytes = 4;
            default: nbytes = 6;
        endcase
        // field is little endian from byte s
        for (int k = 0; k < nbytes; k++) begin
            r.offset[8*k +: 8] = b[s+k];
        end
        // ptr16:16, selector goes to the top and the middle is cleared
        if (far && has66) begin
            r.offset[47:32] = r.offset[31:16];
            r.offset[31:16] = 16'h0000;
        end
        r.instr_length = 4'(s - 1 + nbytes);
        return r;
    endfunction

    // random filler, then prefixes (0x66 last when asked) and the opcode
    function automatic logic [`WINDOW_BYTES*8-1:0] build_window(input int npfx, input bit with66,
                                                                input logic [7:0] op0,
                                                                input logic [7:0] op1);
        logic [`WINDOW_BYTES*8-1:0] w;
        for (int i = 0; i < `WINDOW_BYTES/4; i++) begin
            w[32*i +: 32] = $random(seed);
        end
        for (int i = 1; i <= npfx; i++) begin
            w[8*(`WINDOW_BYTES-i) +: 8] = (with66 && i == npfx) ? 8'h66 : (i[0] ? 8'h2e : 8'h3e);
        end
        w[8*(`WINDOW_BYTES-npfx-1) +: 8] = op0;
        if (op0 == 8'h0f) begin
            w[8*(`WINDOW_BYTES-npfx-2) +: 8] = op1;
        end
        return w;
    endfunction

    task automatic send_window(input logic [`WINDOW_BYTES*8-1:0] w);
        @(posedge clk);
        in_valid  <= 1'b1;
        in_window <= w;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic check_result(input decode_result_t got, input decode_result_t exp);
        if (got.offset !== exp.offset) begin
            mismatch_count++;
            $display("mismatch at %0t: offset got %h expected %h", $time, got.offset, exp.offset);
        end
        if (got.instr_length !== exp.instr_length) begin
            mismatch_count++;
            $display("mismatch at %0t: instr_length got %0d expected %0d", $time,
                     got.instr_length, exp.instr_length);
        end
        if (got.illegal !== exp.illegal) begin
            mismatch_count++;
            $display("mismatch at %0t: illegal got %b expected %b", $time, got.illegal, exp.illegal);
        end
    endtask

    // out_valid must be low whenever no result is due
    task automatic check_idle(input logic valid);
        if (valid !== 1'b0) begin
            protocol_count++;
            $display("out_valid was %b at %0t although no result was due", valid, $time);
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            protocol_count++;
            $display("timed out at %0t with %0d results still outstanding", $time, exp_q.size());
        end
    endtask

    // edge counter, inputs are taken with the values the DUT samples
    // result is due one edge after the sampling edge, two after the edge that drove it
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (reset === 1'b0 && in_valid === 1'b1) begin
            exp_q.push_back(decode_ref(in_window));
            due_q.push_back(cyc + 1);
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (cyc > 0) begin
            if (due_q.size() > 0 && due_q[0] == cyc) begin
                if (out_valid !== 1'b1) begin
                    protocol_count++;
                    $display("result due at edge %0d did not arrive at %0t", cyc, $time);
                end else begin
                    check_result(out_result, exp_q[0]);
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                check_idle(out_valid);
            end
        end
    end

    initial begin
        logic [7:0] op_list [0:11];
        logic [7:0] op0;
        logic [7:0] op1;
        op_list = '{8'heb, 8'h74, 8'h7f, 8'he8, 8'he9, 8'h0f,
                    8'hc2, 8'hea, 8'h9a, 8'h90, 8'hc3, 8'h0f};
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_window = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        // quiet pipeline, then one lone input for latency
        idle_cycles(5);
        send_window(build_window(0, 1'b0, 8'heb, 8'h00));
        idle_cycles(4);
        // short jumps and ret imm16 behind 0 to 3 prefixes
        for (int p = 0; p <= 3; p++) begin
            send_window(build_window(p, p == 2, 8'heb, 8'h00));
            send_window(build_window(p, 1'b0, 8'(8'h70 + 4 * p + 1), 8'h00));
            send_window(build_window(p, p == 1, 8'hc2, 8'h00));
        end
        idle_cycles(2);
        // near forms, start bytes 2 to 6
        for (int p = 0; p <= 3; p++) begin
            for (int o = 0; o <= 1; o++) begin
                send_window(build_window(p, o == 1, 8'he8, 8'h00));
                send_window(build_window(p, o == 1, 8'he9, 8'h00));
                send_window(build_window(p, o == 1, 8'h0f, 8'(8'h80 + 5 * p + o)));
            end
        end
        idle_cycles(2);
        // far pointers with and without the override
        for (int p = 0; p <= 3; p++) begin
            for (int o = 0; o <= 1; o++) begin
                send_window(build_window(p, o == 1, 8'hea, 8'h00));
                send_window(build_window(p, o == 1, 8'h9a, 8'h00));
            end
        end
        idle_cycles(2);
        // unknown opcodes and a fourth prefix
        send_window(build_window(0, 1'b0, 8'h90, 8'h00));
        send_window(build_window(2, 1'b1, 8'h0f, 8'h05));
        send_window(build_window(4, 1'b0, 8'heb, 8'h00));
        send_window(build_window(4, 1'b1, 8'hea, 8'h00));
        idle_cycles(3);
        // back to back random stream
        for (int n = 0; n < 200; n++) begin
            op0 = op_list[$unsigned($random(seed)) % 12];
            op1 = $random(seed);
            if (op1[0]) begin
                op1[7:4] = 4'h8;
            end
            send_window(build_window($unsigned($random(seed)) % 5, op1[1], op0, op1));
        end
        idle_cycles(1);
        drain_results();
        // anything that shows up now is a duplicate
        idle_cycles(4);
        $display("errors: %0d mismatches, %0d protocol", mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
hdl/decode_pkg.sv
hdl/instr_length_decoder.sv
hdl/offset_selector.sv
hdl/stage_register.sv
hdl/offset_decode_top.sv
test/offset_decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator and run the offset decoder testbench.
# Pass is decided by the pass line in the simulation output.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary -Wno-fatal -f verilog.f \
    --top-module offset_decode_tb \
    --Mdir obj_dir -o offset_decode_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/offset_decode_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^TESTS PASSED$'; then
    exit 0
fi
exit 1
